//--- dcache_pkg.sv
package dcache_pkg;

    // Bus and line widths
    localparam int addr_bits      = 32;
    localparam int word_bits      = 32;
    localparam int line_bits      = 128;                    // 16-byte line

    // Geometry of the 2 KB array
    localparam int num_ways       = 4;
    localparam int num_sets       = 32;
    localparam int words_per_line = line_bits / word_bits;

    // Address split, derived from the geometry
    localparam int offset_bits    = $clog2(line_bits / 8);  // Byte offset inside a line
    localparam int index_bits     = $clog2(num_sets);
    localparam int tag_bits       = addr_bits - index_bits - offset_bits;
    localparam int word_sel_bits  = $clog2(words_per_line);

    // Replacement counters saturate at age_max
    localparam int age_bits       = 2;
    localparam int age_max        = (1 << age_bits) - 1;

    typedef logic [addr_bits-1:0]                     addr_t;
    typedef logic [word_bits-1:0]                     word_t;
    typedef logic [words_per_line-1:0][word_bits-1:0] line_t;     // Word 0 in the low bits
    typedef logic [tag_bits-1:0]                      tag_t;
    typedef logic [index_bits-1:0]                    index_t;
    typedef logic [word_sel_bits-1:0]                 word_sel_t;
    typedef logic [$clog2(num_ways)-1:0]              way_t;

    // Fields of a CPU address from the MSB down
    typedef struct packed {
        tag_t                                    tag;
        index_t                                  index;
        word_sel_t                               word_sel;
        logic [offset_bits-word_sel_bits-1:0]    byte_off; // Always 0 for word access
    } addr_fields_t;

    // Same word seen flat or split into fields
    typedef union packed {
        addr_t        flat;
        addr_fields_t fields;
    } addr_u;

    typedef struct packed {
        logic  we;
        addr_u addr;
        word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  req;
        logic  we;      // 1 = write-back, 0 = line fetch
        addr_t addr;    // Line aligned
        line_t wdata;
    } mem_req_t;

endpackage

//--- dcache_tag_array.sv
`timescale 1ns/1ps

module dcache_tag_array (
    input  logic              cpu_clk,
    input  logic              cpu_rst_n,
    input  dcache_pkg::index_t index,        // Set under lookup
    input  dcache_pkg::tag_t   tag,          // Request tag
    input  logic              touch,        // Commit access to access_way
    input  logic              write,        // Access is a CPU write
    output logic              hit,
    output logic              victim_dirty,
    output dcache_pkg::tag_t   victim_tag,
    output dcache_pkg::way_t   access_way    // Hit way, else victim way
);

    import dcache_pkg::*;

    // Per-way control bits
    typedef struct packed {
        logic                valid;
        logic                dirty;
        logic [age_bits-1:0] age;
    } way_state_t;

    way_state_t          state_q [num_sets][num_ways];
    tag_t                tag_q   [num_sets][num_ways];

    logic [num_ways-1:0] hit_vec;
    way_t                hit_way;
    way_t                victim_way;
    way_t                inv_way;
    way_t                old_way;
    logic                inv_found;
    logic [age_bits-1:0] old_age;

    // Compare all ways of the set in parallel
    always_comb begin
        hit_vec = '0;
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (state_q[index][w].valid && (tag_q[index][w] == tag)) begin
                hit_vec[w] = 1'b1;
                hit_way    = way_t'(w);
            end
        end
    end

    assign hit = |hit_vec;

    // Lowest invalid way first, else oldest way with lowest number on a tie
    always_comb begin
        inv_found = 1'b0;
        inv_way   = '0;
        old_way   = '0;
        old_age   = state_q[index][0].age;
        for (int w = 0; w < num_ways; w++) begin
            if (!state_q[index][w].valid && !inv_found) begin
                inv_found = 1'b1;
                inv_way   = way_t'(w);
            end
            if (state_q[index][w].age > old_age) begin   // Strict compare keeps the lower way
                old_age = state_q[index][w].age;
                old_way = way_t'(w);
            end
        end
        victim_way = inv_found ? inv_way : old_way;
    end

    assign access_way   = hit ? hit_way : victim_way;
    assign victim_tag   = tag_q[index][victim_way];
    assign victim_dirty = state_q[index][victim_way].valid & state_q[index][victim_way].dirty;

    // Valid, dirty and age update on every committed access
    always_ff @(posedge cpu_clk or negedge cpu_rst_n) begin
        if (!cpu_rst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                for (int w = 0; w < num_ways; w++) begin
                    state_q[s][w] <= '0;    // All invalid, age 0
                end
            end
        end else if (touch) begin
            for (int w = 0; w < num_ways; w++) begin
                if (way_t'(w) == access_way) begin
                    state_q[index][w].valid <= 1'b1;
                    state_q[index][w].dirty <= (hit & state_q[index][w].dirty) | write; // Fill starts clean
                    state_q[index][w].age   <= '0;                                      // Most recent
                end else if (state_q[index][w].valid &&
                             (state_q[index][w].age < age_bits'(age_max))) begin
                    state_q[index][w].age <= state_q[index][w].age + 1'b1;  // Saturating
                end
            end
        end
    end

    // Request tag into the accessed way
    always_ff @(posedge cpu_clk) begin
        if (touch) begin
            tag_q[index][access_way] <= tag;
        end
    end

    // A line may live in one way of its set only
    a_single_hit: assert property (@(posedge cpu_clk) disable iff (!cpu_rst_n)
        $onehot0(hit_vec))
        else $error("tag array: tag %h found in more than one way of set %0d", tag, index);

endmodule

//--- dcache_data_array.sv
`timescale 1ns/1ps

module dcache_data_array (
    input  logic                  cpu_clk,
    input  dcache_pkg::index_t     index,
    input  dcache_pkg::way_t       way,          // Way being accessed or evicted
    input  dcache_pkg::word_sel_t  word_sel,
    input  logic                  we,           // Merge wdata into the line
    input  dcache_pkg::word_t      wdata,
    input  dcache_pkg::line_t      fill_line,    // Line from main memory
    input  logic                  use_fill,
    input  logic                  line_we,
    output dcache_pkg::word_t      rdata_word,
    output dcache_pkg::line_t      victim_line
);

    import dcache_pkg::*;

    line_t lines_q [num_sets][num_ways];
    line_t stored_line;
    line_t merged_line;

    assign stored_line = lines_q[index][way];

    // Base line from memory on a refill, else the cached copy
    always_comb begin
        merged_line = use_fill ? fill_line : stored_line;
        if (we) begin
            merged_line[word_sel] = wdata;  // Write word wins over the fetched one
        end
    end

    // CPU sees the line as it will be after the access
    assign rdata_word  = merged_line[word_sel];
    assign victim_line = stored_line;       // Old contents for write-back

    always_ff @(posedge cpu_clk) begin
        if (line_we) begin
            lines_q[index][way] <= merged_line;
        end
    end

endmodule

//--- dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                 cpu_clk,
    input  logic                 cpu_rst_n,
    input  logic                 cpu_req,
    input  dcache_pkg::cpu_req_t  cpu_in,
    input  logic                 hit,
    input  logic                 victim_dirty,
    input  dcache_pkg::tag_t      victim_tag,
    input  dcache_pkg::line_t     victim_line,
    input  logic                 mem_ready,      // Write-back accepted
    input  logic                 mem_valid,      // Fetched line on mem_rdata
    output logic                 cpu_ready,
    output logic                 cpu_valid,
    output logic                 cpu_hit,
    output logic                 cpu_miss,
    output dcache_pkg::cpu_req_t  req_q,          // Request under service
    output logic                 touch,
    output logic                 line_we,
    output logic                 use_fill,
    output dcache_pkg::mem_req_t  mem_out
);

    import dcache_pkg::*;

    typedef enum logic [1:0] {
        s_idle,     // Waiting for the CPU
        s_lookup,   // Tag compare on the registered request
        s_wb,       // Dirty victim out to memory
        s_fetch     // Line read from memory
    } state_e;

    state_e state_q;
    state_e state_d;
    addr_t  wb_addr;
    addr_t  fetch_addr;

    // Victim line address rebuilt from its stored tag
    assign wb_addr    = {victim_tag, req_q.addr.fields.index, {offset_bits{1'b0}}};
    assign fetch_addr = {req_q.addr.fields.tag, req_q.addr.fields.index, {offset_bits{1'b0}}};

    always_ff @(posedge cpu_clk or negedge cpu_rst_n) begin
        if (!cpu_rst_n) begin
            state_q <= s_idle;
            req_q   <= '0;
        end else begin
            state_q <= state_d;
            if (cpu_req && cpu_ready) begin
                req_q <= cpu_in;    // Held until the access ends
            end
        end
    end

    always_comb begin
        state_d   = state_q;
        cpu_ready = 1'b0;
        cpu_valid = 1'b0;
        cpu_hit   = 1'b0;
        cpu_miss  = 1'b0;
        touch     = 1'b0;
        line_we   = 1'b0;
        use_fill  = 1'b0;
        mem_out   = '0;

        case (state_q)
            s_idle: begin
                cpu_ready = 1'b1;
                if (cpu_req) begin
                    state_d = s_lookup;
                end
            end

            s_lookup: begin
                if (hit) begin
                    // Read or write completes here, one cycle after acceptance
                    cpu_hit   = 1'b1;
                    cpu_valid = 1'b1;
                    touch     = 1'b1;
                    line_we   = 1'b1;
                    state_d   = s_idle;
                end else begin
                    cpu_miss = 1'b1;
                    state_d  = victim_dirty ? s_wb : s_fetch;
                end
            end

            s_wb: begin
                mem_out.req   = 1'b1;
                mem_out.we    = 1'b1;
                mem_out.addr  = wb_addr;
                mem_out.wdata = victim_line;
                if (mem_ready) begin
                    state_d = s_fetch;  // Victim is in memory so the new line can be fetched
                end
            end

            s_fetch: begin
                mem_out.req  = 1'b1;
                mem_out.addr = fetch_addr;
                if (mem_valid) begin
                    // Refill, merge and answer in the same cycle
                    use_fill  = 1'b1;
                    touch     = 1'b1;
                    line_we   = 1'b1;
                    cpu_valid = 1'b1;
                    state_d   = s_idle;
                end
            end

            default: begin
                state_d = s_idle;
            end
        endcase
    end

    // Memory sees a steady request until it answers
    a_mem_hold: assert property (@(posedge cpu_clk) disable iff (!cpu_rst_n)
        mem_out.req && !(mem_out.we ? mem_ready : mem_valid) |=>
            mem_out.req && $stable(mem_out.we) && $stable(mem_out.addr) &&
            $stable(mem_out.wdata))
        else $error("dcache ctrl: memory request changed before completion");

    // No new request is taken in the cycle that finishes one
    a_valid_not_ready: assert property (@(posedge cpu_clk) disable iff (!cpu_rst_n)
        !(cpu_valid && cpu_ready))
        else $error("dcache ctrl: cpu_valid and cpu_ready high together");

endmodule

//--- dcache.sv
`timescale 1ns/1ps

module dcache (
    input  logic             cpu_clk,
    input  logic             cpu_rst_n,
    input  logic             cpu_req,
    input  logic             cpu_we,
    input  dcache_pkg::addr_t cpu_addr,     // Word aligned
    input  dcache_pkg::word_t cpu_wdata,
    output dcache_pkg::word_t cpu_rdata,    // Valid with cpu_valid
    output logic             cpu_ready,
    output logic             cpu_valid,
    output logic             cpu_hit,
    output logic             cpu_miss,
    output logic             mem_req,
    output logic             mem_we,
    output dcache_pkg::addr_t mem_addr,     // Line aligned
    output dcache_pkg::line_t mem_wdata,
    input  dcache_pkg::line_t mem_rdata,
    input  logic             mem_ready,
    input  logic             mem_valid
);

    import dcache_pkg::*;

    cpu_req_t cpu_in;
    cpu_req_t req_q;
    mem_req_t mem_out;
    logic     hit;
    logic     victim_dirty;
    tag_t     victim_tag;
    way_t     access_way;
    line_t    victim_line;
    logic     touch;
    logic     line_we;
    logic     use_fill;

    assign cpu_in.we        = cpu_we;
    assign cpu_in.addr.flat = cpu_addr;
    assign cpu_in.wdata     = cpu_wdata;

    assign mem_req   = mem_out.req;
    assign mem_we    = mem_out.we;
    assign mem_addr  = mem_out.addr;
    assign mem_wdata = mem_out.wdata;

    dcache_ctrl i_ctrl (
        .cpu_clk      (cpu_clk),
        .cpu_rst_n    (cpu_rst_n),
        .cpu_req      (cpu_req),
        .cpu_in       (cpu_in),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line),
        .mem_ready    (mem_ready),
        .mem_valid    (mem_valid),
        .cpu_ready    (cpu_ready),
        .cpu_valid    (cpu_valid),
        .cpu_hit      (cpu_hit),
        .cpu_miss     (cpu_miss),
        .req_q        (req_q),
        .touch        (touch),
        .line_we      (line_we),
        .use_fill     (use_fill),
        .mem_out      (mem_out)
    );

    dcache_tag_array i_tag_array (
        .cpu_clk      (cpu_clk),
        .cpu_rst_n    (cpu_rst_n),
        .index        (req_q.addr.fields.index),
        .tag          (req_q.addr.fields.tag),
        .touch        (touch),
        .write        (req_q.we),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .access_way   (access_way)
    );

    dcache_data_array i_data_array (
        .cpu_clk      (cpu_clk),
        .index        (req_q.addr.fields.index),
        .way          (access_way),
        .word_sel     (req_q.addr.fields.word_sel),
        .we           (req_q.we),
        .wdata        (req_q.wdata),
        .fill_line    (mem_rdata),
        .use_fill     (use_fill),
        .line_we      (line_we),
        .rdata_word   (cpu_rdata),
        .victim_line  (victim_line)
    );

endmodule

//--- tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
    input  logic              cpu_clk,
    input  logic              cpu_rst_n,
    input  logic              mem_req,
    input  logic              mem_we,
    input  dcache_pkg::addr_t mem_addr,
    input  dcache_pkg::line_t mem_wdata,
    output dcache_pkg::line_t mem_rdata,
    output logic              mem_ready,     // One-cycle write acknowledge
    output logic              mem_valid      // One-cycle read data strobe
);

    import dcache_pkg::*;

    word_t       words [addr_t];             // Sparse store of written words
    addr_t       wb_addr_log [$];            // One entry per write-back
    line_t       wb_line_log [$];
    logic [31:0] delay_state = 32'h5e32_024a;
    logic        busy;
    int unsigned wait_cnt;

    // Every address bit shows up in the background word
    function automatic word_t background_word(addr_t a);
        return {a[15:0], a[31:16]} ^ 32'h9e37_79b9;
    endfunction

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t read_word(addr_t a);
        if (words.exists(a)) return words[a];
        return background_word(a);
    endfunction

    always @(posedge cpu_clk or negedge cpu_rst_n) begin
        if (!cpu_rst_n) begin
            busy      <= 1'b0;
            wait_cnt  <= 0;
            mem_ready <= 1'b0;
            mem_valid <= 1'b0;
            mem_rdata <= '0;
        end else begin
            mem_ready <= 1'b0;
            mem_valid <= 1'b0;
            mem_rdata <= {words_per_line{32'hdead_beef}};  // Junk outside the data cycle
            if (busy) begin
                if (wait_cnt == 0) begin
                    busy <= 1'b0;
                    if (mem_we) begin
                        mem_ready <= 1'b1;
                        for (int i = 0; i < words_per_line; i++) begin
                            words[mem_addr + addr_t'(4 * i)] = mem_wdata[i];
                        end
                        wb_addr_log.push_back(mem_addr);
                        wb_line_log.push_back(mem_wdata);
                    end else begin
                        mem_valid <= 1'b1;
                        for (int i = 0; i < words_per_line; i++) begin
                            mem_rdata[i] <= read_word(mem_addr + addr_t'(4 * i));
                        end
                    end
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end else if (mem_req && !mem_ready && !mem_valid) begin  // Skip the answered request
                delay_state = xorshift(delay_state);
                wait_cnt    <= delay_state % 6;                      // 0 to 5 extra cycles
                busy        <= 1'b1;
            end
        end
    end

endmodule

//--- tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

    import dcache_pkg::*;

    logic        cpu_clk;
    logic        cpu_rst_n;
    logic        cpu_req;
    logic        cpu_we;
    addr_t       cpu_addr;
    word_t       cpu_wdata;
    word_t       cpu_rdata;
    logic        cpu_ready;
    logic        cpu_valid;
    logic        cpu_hit;
    logic        cpu_miss;
    logic        mem_req;
    logic        mem_we;
    addr_t       mem_addr;
    line_t       mem_wdata;
    line_t       mem_rdata;
    logic        mem_ready;
    logic        mem_valid;

    word_t       shadow_mem [addr_t];         // Architectural memory of the written words
    logic        sh_valid [num_sets][num_ways];
    logic        sh_dirty [num_sets][num_ways];
    tag_t        sh_tag   [num_sets][num_ways];
    int          sh_age   [num_sets][num_ways];
    logic [31:0] rng_state;
    cpu_req_t    rq;
    cpu_req_t    rq2;
    logic [31:0] rnd;

    initial begin
        cpu_clk = 1'b0;
        forever #2 cpu_clk = ~cpu_clk;        // 4 ns period
    end

    dcache i_dcache (.*);

    tb_mem_model i_mem (.*);

    // Same fill pattern as the memory model
    function automatic word_t background_word(addr_t a);
        return {a[15:0], a[31:16]} ^ 32'h9e37_79b9;
    endfunction

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // Reference model of the word the CPU sees once the access is done
    function automatic word_t expected_word(addr_t a, logic we, word_t wdata);
        if (we) return wdata;
        if (shadow_mem.exists(a)) return shadow_mem[a];
        return background_word(a);
    endfunction

    function automatic line_t shadow_line(addr_t base);
        line_t l;
        for (int i = 0; i < words_per_line; i++) begin
            l[i] = expected_word(base + addr_t'(4 * i), 1'b0, '0);
        end
        return l;
    endfunction

    function automatic cpu_req_t make_req(logic we, tag_t tg, index_t idx, word_sel_t ws,
                                          word_t wdata);
        cpu_req_t r;
        r.we                   = we;
        r.addr.fields.tag      = tg;
        r.addr.fields.index    = idx;
        r.addr.fields.word_sel = ws;
        r.addr.fields.byte_off = '0;
        r.wdata                = wdata;
        return r;
    endfunction

    // Hit way, else lowest invalid way, else oldest with the lowest number
    function automatic int pick_way(index_t idx, tag_t tg, output logic is_hit);
        int way;
        int oldest;
        is_hit = 1'b0;
        way    = -1;
        for (int w = 0; w < num_ways; w++) begin
            if (sh_valid[idx][w] && sh_tag[idx][w] == tg) begin
                is_hit = 1'b1;
                way    = w;
            end
        end
        if (!is_hit) begin
            for (int w = num_ways - 1; w >= 0; w--) begin
                if (!sh_valid[idx][w]) way = w;
            end
            if (way < 0) begin
                oldest = 0;
                for (int w = 1; w < num_ways; w++) begin
                    if (sh_age[idx][w] > sh_age[idx][oldest]) oldest = w;
                end
                way = oldest;
            end
        end
        return way;
    endfunction

    task automatic update_shadow(index_t idx, int way, tag_t tg, logic is_hit, logic we);
        for (int w = 0; w < num_ways; w++) begin
            if (w == way) begin
                sh_dirty[idx][w] = (is_hit & sh_dirty[idx][w]) | we;  // Fill starts clean
                sh_valid[idx][w] = 1'b1;
                sh_tag[idx][w]   = tg;
                sh_age[idx][w]   = 0;
            end else if (sh_valid[idx][w] && sh_age[idx][w] < age_max) begin
                sh_age[idx][w]++;
            end
        end
    endtask

    task automatic check_value(string name, logic [127:0] expected, logic [127:0] actual);
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("Checks failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic fail_timeout(string what);
        $display("Timed out waiting for %s", what);
        $display("Checks failed");
        $fatal(1, "stopped on timeout");
    endtask

    // One CPU access checked against the reference and the shadow tags
    task automatic run_access(string name, cpu_req_t req);
        index_t idx;
        tag_t   tg;
        int     way;
        logic   is_hit;
        logic   wb_expected;
        addr_t  victim_base;
        line_t  victim_data;
        int     log_before;
        int     n;
        idx         = req.addr.fields.index;
        tg          = req.addr.fields.tag;
        way         = pick_way(idx, tg, is_hit);
        wb_expected = !is_hit && sh_valid[idx][way] && sh_dirty[idx][way];
        victim_base = {sh_tag[idx][way], idx, {offset_bits{1'b0}}};
        victim_data = shadow_line(victim_base);
        log_before  = i_mem.wb_addr_log.size();
        n = 0;
        @(negedge cpu_clk);
        while (!cpu_ready) begin               // Previous access still draining
            @(negedge cpu_clk);
            n++;
            if (n > 100) fail_timeout("cpu_ready");
        end
        @(posedge cpu_clk);
        cpu_req   <= 1'b1;
        cpu_we    <= req.we;
        cpu_addr  <= req.addr.flat;
        cpu_wdata <= req.wdata;
        @(posedge cpu_clk);                     // Accepted here
        cpu_req   <= 1'b0;
        @(negedge cpu_clk);                     // Lookup cycle
        check_value({name, " hit"}, 128'(is_hit), 128'(cpu_hit));
        check_value({name, " miss"}, 128'(!is_hit), 128'(cpu_miss));
        check_value({name, " valid"}, 128'(is_hit), 128'(cpu_valid));
        n = 0;
        while (!cpu_valid) begin
            @(negedge cpu_clk);
            n++;
            if (n > 100) fail_timeout("cpu_valid after a miss");
        end
        check_value({name, " rdata"}, 128'(expected_word(req.addr.flat, req.we, req.wdata)),
                    128'(cpu_rdata));
        if (wb_expected) begin
            check_value({name, " wb count"}, 128'(log_before + 1),
                        128'(i_mem.wb_addr_log.size()));
            check_value({name, " wb addr"}, 128'(victim_base),
                        128'(i_mem.wb_addr_log[log_before]));
            check_value({name, " wb data"}, victim_data, i_mem.wb_line_log[log_before]);
        end else begin
            check_value({name, " no wb"}, 128'(log_before), 128'(i_mem.wb_addr_log.size()));
        end
        @(negedge cpu_clk);                     // Access over, one pulse only
        check_value({name, " single valid"}, 128'(1'b0), 128'(cpu_valid));
        check_value({name, " mem_req idle"}, 128'(1'b0), 128'(mem_req));
        update_shadow(idx, way, tg, is_hit, req.we);
        if (req.we) shadow_mem[req.addr.flat] = req.wdata;
    endtask

    initial begin
        cpu_rst_n  = 1'b0;
        cpu_req    = 1'b0;
        cpu_we     = 1'b0;
        cpu_addr   = '0;
        cpu_wdata  = '0;
        rng_state  = 32'h5e32_024a;
        for (int s = 0; s < num_sets; s++) begin
            for (int w = 0; w < num_ways; w++) begin
                sh_valid[s][w] = 1'b0;
                sh_dirty[s][w] = 1'b0;
                sh_tag[s][w]   = '0;
                sh_age[s][w]   = 0;
            end
        end
        repeat (8) @(posedge cpu_clk);
        cpu_rst_n <= 1'b1;
        @(negedge cpu_clk);
        check_value("reset ready", 128'(1'b1), 128'(cpu_ready));
        check_value("reset valid", 128'(1'b0), 128'(cpu_valid));
        check_value("reset hit", 128'(1'b0), 128'(cpu_hit));
        check_value("reset miss", 128'(1'b0), 128'(cpu_miss));
        check_value("reset mem_req", 128'(1'b0), 128'(mem_req));

        rq = make_req(1'b0, tag_t'(next_rand()), 5'd2, word_sel_t'(next_rand()), '0);
        run_access("first read", rq);
        run_access("read hit", rq);
        rq.we    = 1'b1;
        rq.wdata = next_rand();
        run_access("write hit", rq);
        rq.we    = 1'b0;
        run_access("read after write", rq);

        // Write miss, then the whole line to see the merge
        rq = make_req(1'b1, tag_t'(next_rand()), 5'd11, 2'd1, next_rand());
        run_access("write miss", rq);
        for (int ws = 0; ws < words_per_line; ws++) begin
            rq2 = make_req(1'b0, rq.addr.fields.tag, 5'd11, word_sel_t'(ws), '0);
            run_access("merge read", rq2);
        end

        // Dirty eviction in set 7, clean eviction in set 9
        for (int t = 0; t < 5; t++) begin
            run_access("dirty fill", make_req(t < 4, tag_t'(100 + t), 5'd7, 2'd3, next_rand()));
            run_access("clean fill", make_req(1'b0, tag_t'(300 + t), 5'd9, 2'd0, '0));
        end

        // Random mix over three sets and eight tags
        for (int i = 0; i < 400; i++) begin
            rnd = next_rand();
            rq  = make_req(rnd[0], tag_t'(rnd[10:8]), index_t'(3 + rnd[13:12] % 3),
                           word_sel_t'(rnd[5:4]), next_rand());
            run_access($sformatf("random %0d", i), rq);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

//--- dcache.f
dcache_pkg.sv
dcache_tag_array.sv
dcache_data_array.sv
dcache_ctrl.sv
dcache.sv
tb_mem_model.sv
tb_dcache.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only -Wall --timing
TOP       := tb_dcache
FILELIST  := dcache.f
OBJDIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
